/* design/rv_instr_pkg.sv */
// instruction parcel and word types, 32-bit opcode mark for RISC-V encodings
package rv_instr_pkg;

    // ------------------------------
    // parcel and word types
    // ------------------------------

    // one 16-bit instruction parcel, the unit in which compressed code is laid out
    typedef logic [15:0] halfword_t;

    // one full 32-bit instruction word
    // the fetch word of the 32-bit fetch path uses the same type
    typedef logic [31:0] instr_t;

    // ------------------------------
    // length encoding
    // ------------------------------

    // the two low opcode bits of a parcel give the instruction length
    // 2'b11 opens a 32-bit instruction, anything else is a compressed one
    // longer encodings (48 bit and up) are not supported on this path
    localparam logic [1:0] RV32_LSB_MARK = 2'b11;

endpackage

/* design/realign_pkg.sv */
// re-aligner state enum, decode and plan structs, slot-0 source enum, parcel widening
package realign_pkg;
    import rv_instr_pkg::*;

    // ------------------------------
    // straddle state
    // ------------------------------

    // STRADDLE means the lower half of a 32-bit instruction is held
    // and waits for its upper half in the next fetch word
    typedef enum logic {
        ALIGNED  = 1'b0,
        STRADDLE = 1'b1
    } realign_state_e;

    // ------------------------------
    // decode of one fetch word
    // ------------------------------

    // per-halfword length class plus the odd-halfword entry flag
    typedef struct packed {
        logic lo_compressed;
        logic hi_compressed;
        logic entry_upper;
    } decode_t;

    // ------------------------------
    // slot plan
    // ------------------------------

    // where the slot-0 instruction word comes from
    typedef enum logic [2:0] {
        SRC_WORD   = 3'd0,  // full fetch word at the fetch address
        SRC_LO_C   = 3'd1,  // low halfword, compressed
        SRC_HI_C   = 3'd2,  // upper halfword, compressed
        SRC_STITCH = 3'd3,  // low halfword joined above the held halfword
        SRC_NONE   = 3'd4   // nothing to issue from slot 0
    } slot0_src_e;

    // capture_hi asks for the upper halfword and its address to be held
    typedef struct packed {
        slot0_src_e slot0_src;
        logic       slot1_valid;
        logic       capture_hi;
    } plan_t;

    // a compressed parcel is handed on as a 32-bit word with zero upper bits
    function automatic instr_t zext_half(halfword_t half);
        return {16'b0, half};
    endfunction

endpackage

/* design/parcel_decode.sv */
// parcel_decode module: compressed test of both halfwords and unaligned-entry flag
`timescale 1ns/100ps

module parcel_decode
    import rv_instr_pkg::*;
    import realign_pkg::*;
(
    input  instr_t  data_i,
    input  logic    entry_upper_i,
    output decode_t dec_o
);

    // ------------------------------
    // parcel split
    // ------------------------------

    // the fetch word is little endian, so the parcel at the lower address
    // sits in bits 15:0
    halfword_t lo_half;
    halfword_t hi_half;

    assign lo_half = data_i[15:0];
    assign hi_half = data_i[31:16];

    // ------------------------------
    // length class
    // ------------------------------

    // a parcel whose low bits differ from the 32-bit mark is a complete
    // compressed instruction on its own
    // this is also applied to parcels that are really the upper half of a
    // straddling instruction, the execute stage decides which result counts
    logic lo_is_c;
    logic hi_is_c;

    assign lo_is_c = (lo_half[1:0] != RV32_LSB_MARK);
    assign hi_is_c = (hi_half[1:0] != RV32_LSB_MARK);

    // entry at an odd halfword comes from bit 1 of the fetch address,
    // typically a branch or jump target
    always_comb begin : pack_decode
        dec_o.lo_compressed = lo_is_c;
        dec_o.hi_compressed = hi_is_c;
        dec_o.entry_upper   = entry_upper_i;
    end

endmodule

/* design/realign_execute.sv */
// realign_execute module: straddle FSM, held halfword and address, slot plan selection
`timescale 1ns/100ps

module realign_execute
    import rv_instr_pkg::*;
    import realign_pkg::*;
#(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    input  logic                  valid_i,
    input  logic [ADDR_WIDTH-1:0] address_i,
    input  halfword_t             hi_half_i,
    input  decode_t               dec_i,
    output plan_t                 plan_o,
    output halfword_t             held_half_o,
    output logic [ADDR_WIDTH-1:0] held_addr_o,
    output logic                  serving_unaligned_o
);

    realign_state_e        state_q;
    realign_state_e        state_d;
    halfword_t             held_half_q;
    logic [ADDR_WIDTH-1:0] held_addr_q;
    logic [ADDR_WIDTH-1:0] hi_addr;

    // address of the upper halfword of this fetch word
    // for an odd entry this is the fetch address itself
    assign hi_addr = {address_i[ADDR_WIDTH-1:2], 1'b1, address_i[0]};

    // ------------------------------
    // plan selection
    // ------------------------------

    always_comb begin : plan_select
        plan_o.slot0_src   = SRC_NONE;
        plan_o.slot1_valid = 1'b0;
        plan_o.capture_hi  = 1'b0;
        state_d            = state_q;

        if (dec_i.entry_upper) begin
            // on odd entry the low halfword is not part of the stream
            // and any halfword still held belongs to the old path and is dropped
            if (dec_i.hi_compressed) begin
                plan_o.slot0_src = SRC_HI_C;
                state_d          = ALIGNED;
            end else begin
                // only the lower half of the target is here and the rest
                // arrives with the next fetch word
                plan_o.capture_hi = 1'b1;
                state_d           = STRADDLE;
            end
        end else if ((state_q == STRADDLE) || dec_i.lo_compressed) begin
            // slot 0 takes the low halfword, either completing the held
            // instruction or as a compressed one of its own
            if (state_q == STRADDLE) begin
                plan_o.slot0_src = SRC_STITCH;
            end else begin
                plan_o.slot0_src = SRC_LO_C;
            end

            // the upper halfword then opens a new instruction
            if (dec_i.hi_compressed) begin
                plan_o.slot1_valid = 1'b1;
                state_d            = ALIGNED;
            end else begin
                plan_o.capture_hi = 1'b1;
                state_d           = STRADDLE;
            end
        end else begin
            // plain 32-bit instruction filling the whole word
            plan_o.slot0_src = SRC_WORD;
            state_d          = ALIGNED;
        end
    end

    // ------------------------------
    // state and held parcel
    // ------------------------------

    // flush wins over a fetch in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin : state_reg
        if (!rst_ni) begin
            state_q <= ALIGNED;
        end else if (flush_i) begin
            state_q <= ALIGNED;
        end else if (valid_i) begin
            state_q <= state_d;
        end
    end

    // the upper halfword and its address are taken whenever the plan captures them
    always_ff @(posedge clk_i or negedge rst_ni) begin : held_reg
        if (!rst_ni) begin
            held_half_q <= '0;
            held_addr_q <= '0;
        end else if (valid_i && plan_o.capture_hi) begin
            held_half_q <= hi_half_i;
            held_addr_q <= hi_addr;
        end
    end

    assign held_half_o         = held_half_q;
    assign held_addr_o         = held_addr_q;
    assign serving_unaligned_o = (state_q == STRADDLE);

endmodule

/* design/slot_result.sv */
// slot_result module: instruction words, addresses and valids of the two output slots
`timescale 1ns/100ps

module slot_result
    import rv_instr_pkg::*;
    import realign_pkg::*;
#(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                       valid_i,
    input  logic [ADDR_WIDTH-1:0]      address_i,
    input  instr_t                     data_i,
    input  plan_t                      plan_i,
    input  halfword_t                  held_half_i,
    input  logic [ADDR_WIDTH-1:0]      held_addr_i,
    output logic [1:0]                 valid_o,
    output instr_t [1:0]               instr_o,
    output logic [1:0][ADDR_WIDTH-1:0] addr_o
);

    halfword_t lo_half;
    halfword_t hi_half;

    assign lo_half = data_i[15:0];
    assign hi_half = data_i[31:16];

    // ------------------------------
    // slot 0
    // ------------------------------

    always_comb begin : slot0_mux
        // every source except the stitch issues at the fetch address
        addr_o[0] = address_i;

        case (plan_i.slot0_src)
            SRC_WORD: begin
                instr_o[0] = data_i;
            end
            SRC_LO_C: begin
                instr_o[0] = zext_half(lo_half);
            end
            SRC_HI_C: begin
                // odd entry, the fetch address already points at the upper halfword
                instr_o[0] = zext_half(hi_half);
            end
            SRC_STITCH: begin
                // held lower half below, the new low halfword on top,
                // issued where the instruction started
                instr_o[0] = {lo_half, held_half_i};
                addr_o[0]  = held_addr_i;
            end
            default: begin
                instr_o[0] = '0;
            end
        endcase
    end

    // ------------------------------
    // slot 1
    // ------------------------------

    // slot 1 only ever carries a compressed upper halfword
    assign instr_o[1] = zext_half(hi_half);
    assign addr_o[1]  = {address_i[ADDR_WIDTH-1:2], 1'b1, address_i[0]};

    // ------------------------------
    // valids
    // ------------------------------

    // nothing issues without a fetch word, whatever the plan says
    assign valid_o[0] = valid_i && (plan_i.slot0_src != SRC_NONE);
    assign valid_o[1] = valid_i && plan_i.slot1_valid;

endmodule

/* design/instr_realign_top.sv */
// instr_realign_top module: parcel decode, straddle execute and slot result wired together
`timescale 1ns/100ps

module instr_realign_top
    import rv_instr_pkg::*;
    import realign_pkg::*;
#(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_i,
    input  logic                       valid_i,
    input  logic [ADDR_WIDTH-1:0]      address_i,
    input  instr_t                     data_i,
    output logic [1:0]                 valid_o,
    output instr_t [1:0]               instr_o,
    output logic [1:0][ADDR_WIDTH-1:0] addr_o,
    output logic                       serving_unaligned_o
);

    decode_t               dec;
    plan_t                 plan;
    halfword_t             held_half;
    logic [ADDR_WIDTH-1:0] held_addr;

    // ------------------------------
    // decode
    // ------------------------------

    // bit 1 of the fetch address marks entry at the upper halfword
    parcel_decode decode0 (
        .data_i        (data_i),
        .entry_upper_i (address_i[1]),
        .dec_o         (dec)
    );

    // ------------------------------
    // execute
    // ------------------------------

    // only the upper halfword can ever be held across fetch words
    realign_execute #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) execute0 (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .valid_i             (valid_i),
        .address_i           (address_i),
        .hi_half_i           (data_i[31:16]),
        .dec_i               (dec),
        .plan_o              (plan),
        .held_half_o         (held_half),
        .held_addr_o         (held_addr),
        .serving_unaligned_o (serving_unaligned_o)
    );

    // ------------------------------
    // result
    // ------------------------------

    slot_result #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) result0 (
        .valid_i     (valid_i),
        .address_i   (address_i),
        .data_i      (data_i),
        .plan_i      (plan),
        .held_half_i (held_half),
        .held_addr_i (held_addr),
        .valid_o     (valid_o),
        .instr_o     (instr_o),
        .addr_o      (addr_o)
    );

endmodule

/* sim/realign_checker.sv */
// realign_checker module: compares DUT slot outputs and status with the reference slots
`timescale 1ns/100ps

module realign_checker
    import rv_instr_pkg::*;
#(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    // DUT outputs
    input  logic [1:0]                 valid_i,
    input  instr_t [1:0]               instr_i,
    input  logic [1:0][ADDR_WIDTH-1:0] addr_i,
    input  logic                       serving_unaligned_i,
    // reference slots
    input  logic [1:0]                 exp_valid_i,
    input  instr_t                     exp_instr0_i,
    input  instr_t                     exp_instr1_i,
    input  logic [ADDR_WIDTH-1:0]      exp_addr0_i,
    input  logic [ADDR_WIDTH-1:0]      exp_addr1_i,
    input  logic                       exp_serving_i,
    output int                         check_count_o,
    output int                         error_count_o
);

    int check_q = 0;
    int error_q = 0;

    // ------------------------------
    // single compare
    // ------------------------------

    // each field arrives widened to 64 bits
    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
        check_q = check_q + 1;
        if (got !== expected) begin
            error_q = error_q + 1;
            $display("ERROR %s got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    // ------------------------------
    // per-cycle compare
    // ------------------------------

    // the DUT outputs are combinational from inputs that change on the
    // rising edge, so the falling edge sees them settled
    always @(negedge clk_i) begin : slot_compare
        if (rst_ni) begin
            compare_field("valid_o", 64'(valid_i), 64'(exp_valid_i));
            compare_field("serving_unaligned_o", 64'(serving_unaligned_i),
                          64'(exp_serving_i));

            // word and address only mean something for a valid slot
            if (exp_valid_i[0]) begin
                compare_field("instr_o[0]", 64'(instr_i[0]), 64'(exp_instr0_i));
                compare_field("addr_o[0]", 64'(addr_i[0]), 64'(exp_addr0_i));
            end
            if (exp_valid_i[1]) begin
                compare_field("instr_o[1]", 64'(instr_i[1]), 64'(exp_instr1_i));
                compare_field("addr_o[1]", 64'(addr_i[1]), 64'(exp_addr1_i));
            end
        end
    end

    assign check_count_o = check_q;
    assign error_count_o = error_q;

endmodule

/* sim/tb_instr_realign.sv */
// tb_instr_realign testbench: clock, reset, directed and random fetches, reference model, timeout
`timescale 1ns/100ps

module tb_instr_realign
    import rv_instr_pkg::*;
();

    localparam int AW             = 32;
    localparam int RESET_CYCLES   = 2;
    localparam int DIRECTED_CYCLES = 16;
    localparam int RANDOM_CYCLES  = 400;
    localparam int CYCLE_LIMIT    = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 50;

    // expected slots plus what the model does with the upper halfword
    typedef struct packed {
        logic [1:0]    valid;
        instr_t        instr0;
        instr_t        instr1;
        logic [AW-1:0] addr0;
        logic [AW-1:0] addr1;
        logic          capture;
        logic [AW-1:0] cap_addr;
        logic          nxt_straddle;
    } ref_t;

    logic                   clk_i;
    logic                   rst_ni;
    logic                   flush_i;
    logic                   valid_i;
    logic [AW-1:0]          address_i;
    instr_t                 data_i;
    logic [1:0]             valid_o;
    instr_t [1:0]           instr_o;
    logic [1:0][AW-1:0]     addr_o;
    logic                   serving_unaligned_o;

    // model state that updates on the same edges as the DUT
    logic                   m_straddle;
    halfword_t              m_held_half;
    logic [AW-1:0]          m_held_addr;
    ref_t                   exp_slots;
    logic [31:0]            rng = 32'h673b_f31c;
    int                     cycle_cnt = 0;
    int                     check_count;
    int                     error_count;

    // ------------------------------
    // clock and DUT
    // ------------------------------

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    instr_realign_top #(.ADDR_WIDTH(AW)) dut0 (
        .clk_i (clk_i), .rst_ni (rst_ni), .flush_i (flush_i), .valid_i (valid_i),
        .address_i (address_i), .data_i (data_i), .valid_o (valid_o),
        .instr_o (instr_o), .addr_o (addr_o), .serving_unaligned_o (serving_unaligned_o)
    );

    realign_checker #(.ADDR_WIDTH(AW)) checker0 (
        .clk_i (clk_i), .rst_ni (rst_ni), .valid_i (valid_o), .instr_i (instr_o),
        .addr_i (addr_o), .serving_unaligned_i (serving_unaligned_o),
        .exp_valid_i (exp_slots.valid), .exp_instr0_i (exp_slots.instr0),
        .exp_instr1_i (exp_slots.instr1), .exp_addr0_i (exp_slots.addr0),
        .exp_addr1_i (exp_slots.addr1), .exp_serving_i (m_straddle),
        .check_count_o (check_count), .error_count_o (error_count)
    );

    // ------------------------------
    // reference model
    // ------------------------------

    // applies the output rules for one fetch word to the model state
    function automatic ref_t realign_ref(input logic straddle, input halfword_t held,
                                         input logic [AW-1:0] held_addr, input logic valid,
                                         input logic [AW-1:0] a, input instr_t word);
        ref_t      r;
        halfword_t lo;
        halfword_t hi;
        logic      lo_c;
        logic      hi_c;
        logic      upper;
        r     = '0;
        lo    = word[15:0];
        hi    = word[31:16];
        lo_c  = (lo[1:0] != RV32_LSB_MARK);
        hi_c  = (hi[1:0] != RV32_LSB_MARK);
        upper = 1'b0;
        r.nxt_straddle = straddle;
        if (a[1]) begin
            // on odd entry only the upper halfword belongs to the stream
            if (hi_c) begin
                r.valid[0] = 1'b1;
                r.instr0   = {16'h0000, hi};
                r.addr0    = a;
                r.nxt_straddle = 1'b0;
            end else begin
                r.capture  = 1'b1;
                r.cap_addr = a;
                r.nxt_straddle = 1'b1;
            end
        end else begin
            r.valid[0] = 1'b1;
            r.addr0    = a;
            if (straddle) begin
                r.instr0 = {lo, held};
                r.addr0  = held_addr;
                upper    = 1'b1;
            end else if (lo_c) begin
                r.instr0 = {16'h0000, lo};
                upper    = 1'b1;
            end else begin
                r.instr0 = word;
                r.nxt_straddle = 1'b0;
            end
            if (upper && hi_c) begin
                r.valid[1] = 1'b1;
                r.instr1   = {16'h0000, hi};
                r.addr1    = a + AW'(2);
                r.nxt_straddle = 1'b0;
            end else if (upper) begin
                r.capture  = 1'b1;
                r.cap_addr = a + AW'(2);
                r.nxt_straddle = 1'b1;
            end
        end
        if (!valid) begin
            r.valid = 2'b00;
        end
        return r;
    endfunction

    always_comb begin
        exp_slots = realign_ref(m_straddle, m_held_half, m_held_addr, valid_i, address_i, data_i);
    end

    // flush clears the model state and wins over a fetch
    always @(posedge clk_i or negedge rst_ni) begin : model_update
        if (!rst_ni) begin
            m_straddle  <= 1'b0;
            m_held_half <= '0;
            m_held_addr <= '0;
        end else if (flush_i) begin
            m_straddle <= 1'b0;
        end else if (valid_i) begin
            m_straddle <= exp_slots.nxt_straddle;
            if (exp_slots.capture) begin
                m_held_half <= data_i[31:16];
                m_held_addr <= exp_slots.cap_addr;
            end
        end
    end

    // ------------------------------
    // stimulus helpers
    // ------------------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic drive_fetch(input logic v, input logic f, input logic [AW-1:0] a,
                               input instr_t d);
        @(posedge clk_i);
        valid_i   <= v;
        flush_i   <= f;
        address_i <= a;
        data_i    <= d;
    endtask

    // the run ends here if the stimulus never reaches its report
    always @(posedge clk_i) begin : timeout_watch
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ------------------------------
    // test sequence
    // ------------------------------

    initial begin : stimulus
        logic [AW-1:0] addr;
        instr_t        word;
        logic          v;
        logic          f;
        rst_ni    = 1'b0;
        flush_i   = 1'b0;
        valid_i   = 1'b0;
        address_i = '0;
        data_i    = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;

        // full 32-bit word, then two compressed parcels
        drive_fetch(1'b1, 1'b0, 32'h0000_0100, 32'h00a0_0093);
        drive_fetch(1'b1, 1'b0, 32'h0000_0104, 32'h4585_4505);
        // compressed parcel, then a straddling lower half, then its upper half
        drive_fetch(1'b1, 1'b0, 32'h0000_0108, 32'h0513_4501);
        drive_fetch(1'b1, 1'b0, 32'h0000_010c, 32'h4605_00a0);
        // odd entry onto a 32-bit instruction
        drive_fetch(1'b1, 1'b0, 32'h0000_0202, 32'h0593_1234);
        drive_fetch(1'b1, 1'b0, 32'h0000_0204, 32'h4705_0010);
        // flush while a halfword is held
        drive_fetch(1'b1, 1'b0, 32'h0000_0300, 32'h0613_4501);
        drive_fetch(1'b0, 1'b1, 32'h0000_0304, 32'h0000_0000);
        drive_fetch(1'b1, 1'b0, 32'h0000_0400, 32'h00b0_0113);
        // an idle cycle in STRADDLE keeps the held halfword
        drive_fetch(1'b1, 1'b0, 32'h0000_0500, 32'h0693_4501);
        drive_fetch(1'b0, 1'b0, 32'h0000_0504, 32'hdead_beef);
        drive_fetch(1'b1, 1'b0, 32'h0000_0504, 32'h0000_0033);
        // odd entry onto a compressed instruction
        drive_fetch(1'b1, 1'b0, 32'h0000_0602, 32'h4785_ffff);

        // sequential stream with random branches and flushes
        addr = 32'h0000_1000;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            rng = lcg_next(rng);
            if (rng[31:28] == 4'h0) begin
                addr = {16'h0000, rng[15:1], 1'b0};
            end
            f    = (rng[27:24] == 4'h0);
            v    = (rng[23:21] != 3'b000);
            rng  = lcg_next(rng);
            word = rng;
            rng  = lcg_next(rng);
            // force each halfword compressed or 32-bit by its low bits
            word[1:0]   = rng[8] ? 2'b11 : {rng[9], 1'b0};
            word[17:16] = rng[10] ? 2'b11 : {rng[11], 1'b0};
            drive_fetch(v, f, addr, word);
            if (v) begin
                addr = {addr[AW-1:2] + 30'd1, 2'b00};
            end
        end

        drive_fetch(1'b0, 1'b0, '0, '0);
        drive_fetch(1'b0, 1'b0, '0, '0);
        @(negedge clk_i);

        $display("report: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* project.f */
design/rv_instr_pkg.sv
design/realign_pkg.sv
design/parcel_decode.sv
design/realign_execute.sv
design/slot_result.sv
design/instr_realign_top.sv
sim/realign_checker.sv
sim/tb_instr_realign.sv

/* Makefile */
# Verilator build and run of the instruction re-aligner testbench

SRCS := $(wildcard design/*.sv sim/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vtb_instr_realign: project.f $(SRCS)
	verilator --binary --timing -f project.f --top-module tb_instr_realign \
		-o Vtb_instr_realign

# pass or fail comes from the pass message in the simulator output
run: obj_dir/Vtb_instr_realign
	@out="$$(./obj_dir/Vtb_instr_realign)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
